//--- exe_cfg_pkg.sv
package exe_cfg_pkg;

    // operand and result width
    localparam int data_w = 32;

    // destination register number
    localparam int reg_addr_w = 5;

    // one quotient bit per shift-subtract step
    localparam int div_steps = data_w;

    // wide enough to hold div_steps itself
    localparam int step_cnt_w = $clog2(div_steps + 1);

    // shift amount taken from the low bits of the second operand
    localparam int shamt_w = $clog2(data_w);

endpackage

//--- exe_uop_pkg.sv
package exe_uop_pkg;

    typedef enum logic [0:0] {
        cls_alu = 1'b0,
        cls_div = 1'b1
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_nor  = 4'd5,
        alu_sll  = 4'd6,
        alu_srl  = 4'd7,
        alu_sra  = 4'd8,
        alu_slt  = 4'd9,
        alu_sltu = 4'd10
    } alu_op_e;

    // signed and unsigned quotient / remainder
    typedef enum logic [1:0] {
        div_s = 2'd0,
        div_u = 2'd1,
        mod_s = 2'd2,
        mod_u = 2'd3
    } div_op_e;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_run  = 2'd1,
        st_done = 2'd2
    } div_state_e;

endpackage

//--- exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
    input  exe_uop_pkg::alu_op_e              op,
    input  logic [exe_cfg_pkg::data_w-1:0]    src0,
    input  logic [exe_cfg_pkg::data_w-1:0]    src1,
    input  logic [exe_cfg_pkg::data_w-1:0]    imm,
    input  logic                              use_imm,
    output logic [exe_cfg_pkg::data_w-1:0]    result
);

    logic [exe_cfg_pkg::data_w-1:0]  opb;
    logic [exe_cfg_pkg::shamt_w-1:0] shamt;
    logic                            lt_s;
    logic                            lt_u;

    // register-immediate form replaces the second source
    assign opb   = use_imm ? imm : src1;
    assign shamt = opb[exe_cfg_pkg::shamt_w-1:0];

    assign lt_s = $signed(src0) < $signed(opb);
    assign lt_u = src0 < opb;

    always_comb begin
        case (op)
            exe_uop_pkg::alu_add: begin
                result = src0 + opb;
            end
            exe_uop_pkg::alu_sub: begin
                result = src0 - opb;
            end
            exe_uop_pkg::alu_and: begin
                result = src0 & opb;
            end
            exe_uop_pkg::alu_or: begin
                result = src0 | opb;
            end
            exe_uop_pkg::alu_xor: begin
                result = src0 ^ opb;
            end
            exe_uop_pkg::alu_nor: begin
                result = ~(src0 | opb);
            end
            exe_uop_pkg::alu_sll: begin
                result = src0 << shamt;
            end
            exe_uop_pkg::alu_srl: begin
                result = src0 >> shamt;
            end
            exe_uop_pkg::alu_sra: begin
                result = $signed(src0) >>> shamt;
            end
            exe_uop_pkg::alu_slt: begin
                result = {{(exe_cfg_pkg::data_w - 1){1'b0}}, lt_s};
            end
            exe_uop_pkg::alu_sltu: begin
                result = {{(exe_cfg_pkg::data_w - 1){1'b0}}, lt_u};
            end
            // unused encodings
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- div_ctrl.sv
`timescale 1ns/1ps

module div_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  exe_uop_pkg::op_class_e  in_class,
    output logic                    stall,
    output logic                    start,
    output logic                    step,
    output logic                    cnt_load,
    output logic                    cnt_en,
    output logic                    div_done,
    input  logic                    last_step
);

    exe_uop_pkg::div_state_e state_q;
    exe_uop_pkg::div_state_e state_d;

    // a divide is taken only while idle, i.e. while stall is low
    assign start = in_valid && (in_class == exe_uop_pkg::cls_div)
                   && (state_q == exe_uop_pkg::st_idle);

    assign step     = (state_q == exe_uop_pkg::st_run);
    assign cnt_en   = step;
    assign cnt_load = start;
    assign div_done = (state_q == exe_uop_pkg::st_done);

    // pure state decode, independent of in_valid
    assign stall = (state_q != exe_uop_pkg::st_idle);

    always_comb begin
        state_d = state_q;
        case (state_q)
            exe_uop_pkg::st_idle: begin
                if (start) begin
                    state_d = exe_uop_pkg::st_run;
                end
            end
            exe_uop_pkg::st_run: begin
                if (last_step) begin
                    state_d = exe_uop_pkg::st_done;
                end
            end
            default: begin
                state_d = exe_uop_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= exe_uop_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- div_step_counter.sv
`timescale 1ns/1ps

module div_step_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic load,
    input  logic en,
    output logic last_step
);

    logic [exe_cfg_pkg::step_cnt_w-1:0] cnt_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
        end else if (load) begin
            cnt_q <= exe_cfg_pkg::step_cnt_w'(exe_cfg_pkg::div_steps - 1);
        end else if (en && (cnt_q != '0)) begin
            // hold at zero
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign last_step = (cnt_q == '0);

endmodule

//--- div_datapath.sv
`timescale 1ns/1ps

module div_datapath (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                start,
    input  logic                                step,
    input  exe_uop_pkg::div_op_e                op,
    input  logic [exe_cfg_pkg::data_w-1:0]      dividend,
    input  logic [exe_cfg_pkg::data_w-1:0]      divisor,
    input  logic [exe_cfg_pkg::reg_addr_w-1:0]  rd,
    output logic [exe_cfg_pkg::data_w-1:0]      result,
    output logic [exe_cfg_pkg::reg_addr_w-1:0]  result_rd
);

    logic                               is_signed;
    logic                               dvd_neg;
    logic                               dvs_neg;
    logic [exe_cfg_pkg::data_w-1:0]     dvd_mag;
    logic [exe_cfg_pkg::data_w-1:0]     dvs_mag;

    exe_uop_pkg::div_op_e               op_q;
    logic [exe_cfg_pkg::reg_addr_w-1:0] rd_q;
    logic                               q_neg_q;
    logic                               r_neg_q;
    logic                               zero_q;

    logic [exe_cfg_pkg::data_w-1:0]     rem_q;
    logic [exe_cfg_pkg::data_w-1:0]     quo_q;
    logic [exe_cfg_pkg::data_w-1:0]     dvs_q;

    logic [exe_cfg_pkg::data_w:0]       shifted;
    logic [exe_cfg_pkg::data_w:0]       diff;
    logic [exe_cfg_pkg::data_w-1:0]     quo_fix;
    logic [exe_cfg_pkg::data_w-1:0]     rem_fix;

    // operand magnitudes; the most negative value maps to 2^(w-1) unsigned
    assign is_signed = (op == exe_uop_pkg::div_s) || (op == exe_uop_pkg::mod_s);
    assign dvd_neg   = is_signed && dividend[exe_cfg_pkg::data_w-1];
    assign dvs_neg   = is_signed && divisor[exe_cfg_pkg::data_w-1];
    assign dvd_mag   = dvd_neg ? -dividend : dividend;
    assign dvs_mag   = dvs_neg ? -divisor : divisor;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_q    <= exe_uop_pkg::div_s;
            rd_q    <= '0;
            q_neg_q <= 1'b0;
            r_neg_q <= 1'b0;
            zero_q  <= 1'b0;
        end else if (start) begin
            op_q    <= op;
            rd_q    <= rd;
            q_neg_q <= dvd_neg ^ dvs_neg;
            r_neg_q <= dvd_neg;
            zero_q  <= (divisor == '0);
        end
    end

    // restoring step: bring in the next dividend bit, subtract if it fits
    assign shifted = {rem_q, quo_q[exe_cfg_pkg::data_w-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= dvd_mag;
            dvs_q <= dvs_mag;
        end else if (step) begin
            if (!diff[exe_cfg_pkg::data_w]) begin
                rem_q <= diff[exe_cfg_pkg::data_w-1:0];
                quo_q <= {quo_q[exe_cfg_pkg::data_w-2:0], 1'b1};
            end else begin
                rem_q <= shifted[exe_cfg_pkg::data_w-1:0];
                quo_q <= {quo_q[exe_cfg_pkg::data_w-2:0], 1'b0};
            end
        end
    end

    // x/0 gives all ones, remainder keeps the dividend's sign
    assign quo_fix = zero_q ? '1 : (q_neg_q ? -quo_q : quo_q);
    assign rem_fix = r_neg_q ? -rem_q : rem_q;

    assign result = ((op_q == exe_uop_pkg::mod_s) || (op_q == exe_uop_pkg::mod_u))
                    ? rem_fix : quo_fix;
    assign result_rd = rd_q;

endmodule

//--- exe_writeback.sv
`timescale 1ns/1ps

module exe_writeback (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                alu_take,
    input  logic [exe_cfg_pkg::reg_addr_w-1:0]  alu_rd,
    input  logic [exe_cfg_pkg::data_w-1:0]      alu_result,
    input  logic                                div_done,
    input  logic [exe_cfg_pkg::reg_addr_w-1:0]  div_rd,
    input  logic [exe_cfg_pkg::data_w-1:0]      div_result,
    output logic                                wb_valid,
    output logic [exe_cfg_pkg::reg_addr_w-1:0]  wb_rd,
    output logic [exe_cfg_pkg::data_w-1:0]      wb_data
);

    // one pulse per completed op
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= alu_take || div_done;
        end
    end

    // the two sources never coincide since issue is held in done
    always_ff @(posedge clk) begin
        if (div_done) begin
            wb_rd   <= div_rd;
            wb_data <= div_result;
        end else if (alu_take) begin
            wb_rd   <= alu_rd;
            wb_data <= alu_result;
        end
    end

endmodule

//--- exe_top.sv
`timescale 1ns/1ps

module exe_top (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                in_valid,
    input  exe_uop_pkg::op_class_e              in_class,
    input  exe_uop_pkg::alu_op_e                in_alu_op,
    input  exe_uop_pkg::div_op_e                in_div_op,
    input  logic [exe_cfg_pkg::reg_addr_w-1:0]  in_rd,
    input  logic [exe_cfg_pkg::data_w-1:0]      in_src0,
    input  logic [exe_cfg_pkg::data_w-1:0]      in_src1,
    input  logic [exe_cfg_pkg::data_w-1:0]      in_imm,
    input  logic                                in_use_imm,
    output logic                                stall,
    output logic                                wb_valid,
    output logic [exe_cfg_pkg::reg_addr_w-1:0]  wb_rd,
    output logic [exe_cfg_pkg::data_w-1:0]      wb_data
);

    logic                               alu_take;
    logic [exe_cfg_pkg::data_w-1:0]     alu_result;
    logic                               start;
    logic                               step;
    logic                               cnt_load;
    logic                               cnt_en;
    logic                               div_done;
    logic                               last_step;
    logic [exe_cfg_pkg::data_w-1:0]     div_result;
    logic [exe_cfg_pkg::reg_addr_w-1:0] div_rd;

    // alu acceptance
    assign alu_take = in_valid && !stall && (in_class == exe_uop_pkg::cls_alu);

    exe_alu u_alu (
        .op      (in_alu_op),
        .src0    (in_src0),
        .src1    (in_src1),
        .imm     (in_imm),
        .use_imm (in_use_imm),
        .result  (alu_result)
    );

    div_ctrl u_div_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_class  (in_class),
        .stall     (stall),
        .start     (start),
        .step      (step),
        .cnt_load  (cnt_load),
        .cnt_en    (cnt_en),
        .div_done  (div_done),
        .last_step (last_step)
    );

    div_step_counter u_div_cnt (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (cnt_load),
        .en        (cnt_en),
        .last_step (last_step)
    );

    // divides ignore the immediate
    div_datapath u_div_dp (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .step      (step),
        .op        (in_div_op),
        .dividend  (in_src0),
        .divisor   (in_src1),
        .rd        (in_rd),
        .result    (div_result),
        .result_rd (div_rd)
    );

    exe_writeback u_wb (
        .clk        (clk),
        .arst_n     (arst_n),
        .alu_take   (alu_take),
        .alu_rd     (in_rd),
        .alu_result (alu_result),
        .div_done   (div_done),
        .div_rd     (div_rd),
        .div_result (div_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

//--- exe_properties.sv
`timescale 1ns/1ps

module exe_properties (
    input logic clk,
    input logic arst_n,
    input logic stall,
    input logic wb_valid
);

    int stall_len;
    int fail_cnt = 0;

    // consecutive cycles with stall high
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_len <= 0;
        end else if (stall) begin
            stall_len <= stall_len + 1;
        end else begin
            stall_len <= 0;
        end
    end

    reset_quiet: assert property (@(posedge clk) $rose(arst_n) |-> !wb_valid && !stall)
        else begin
            fail_cnt++;
            $error("wb_valid or stall high in the first cycle after reset");
        end

    stall_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        stall_len <= exe_cfg_pkg::div_steps + 1)
        else begin
            fail_cnt++;
            $error("stall held longer than one divide");
        end

    stall_length: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(stall) |-> stall_len == exe_cfg_pkg::div_steps + 1)
        else begin
            fail_cnt++;
            $error("stall fell after %0d cycles", stall_len);
        end

    // divide result leaves as stall drops
    stall_fall_wb: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(stall) |-> wb_valid)
        else begin
            fail_cnt++;
            $error("stall fell without a divide writeback");
        end

endmodule

//--- tb_exe.sv
`timescale 1ns/1ps

module tb_exe;

    typedef logic [exe_cfg_pkg::data_w-1:0] word_t;
    typedef logic [exe_cfg_pkg::reg_addr_w-1:0] rd_t;

    logic                   clk;
    logic                   arst_n;
    logic                   in_valid;
    exe_uop_pkg::op_class_e in_class;
    exe_uop_pkg::alu_op_e   in_alu_op;
    exe_uop_pkg::div_op_e   in_div_op;
    rd_t                    in_rd;
    word_t                  in_src0;
    word_t                  in_src1;
    word_t                  in_imm;
    logic                   in_use_imm;
    logic                   stall;
    logic                   wb_valid;
    rd_t                    wb_rd;
    word_t                  wb_data;

    logic [31:0] lcg_state = 32'd14281;
    int          cyc = 0;
    int          check_errs = 0;
    int          timeouts = 0;
    int          accepted = 0;
    int          data_errs = 0;
    int          proto_errs = 0;
    int          wb_seen = 0;
    int          rd_idx = 0;
    word_t       exp_data[$];
    rd_t         exp_rd[$];
    int          exp_cyc[$];

    exe_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_class   (in_class),
        .in_alu_op  (in_alu_op),
        .in_div_op  (in_div_op),
        .in_rd      (in_rd),
        .in_src0    (in_src0),
        .in_src1    (in_src1),
        .in_imm     (in_imm),
        .in_use_imm (in_use_imm),
        .stall      (stall),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    bind exe_top exe_properties u_props (
        .clk      (clk),
        .arst_n   (arst_n),
        .stall    (stall),
        .wb_valid (wb_valid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // upper half of the state has the better period
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic word_t rand32();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    function automatic word_t alu_model(exe_uop_pkg::alu_op_e op, word_t a, word_t b);
        logic [exe_cfg_pkg::shamt_w-1:0] sh;
        word_t                           r;
        sh = b[exe_cfg_pkg::shamt_w-1:0];
        case (op)
            exe_uop_pkg::alu_add:  r = a + b;
            exe_uop_pkg::alu_sub:  r = a - b;
            exe_uop_pkg::alu_and:  r = a & b;
            exe_uop_pkg::alu_or:   r = a | b;
            exe_uop_pkg::alu_xor:  r = a ^ b;
            exe_uop_pkg::alu_nor:  r = ~(a | b);
            exe_uop_pkg::alu_sll:  r = a << sh;
            exe_uop_pkg::alu_srl:  r = a >> sh;
            exe_uop_pkg::alu_sra:  r = word_t'($signed(a) >>> sh);
            exe_uop_pkg::alu_slt:  r = word_t'($signed(a) < $signed(b));
            exe_uop_pkg::alu_sltu: r = word_t'(a < b);
            default:               r = '0;
        endcase
        return r;
    endfunction

    // truncating divide, remainder takes the dividend's sign
    function automatic word_t div_model(exe_uop_pkg::div_op_e op, word_t a, word_t b);
        word_t min_val;
        logic  ovf;
        min_val = '0;
        min_val[exe_cfg_pkg::data_w-1] = 1'b1;
        ovf = (a == min_val) && (b == '1);
        if (b == '0) begin
            return (op == exe_uop_pkg::div_s || op == exe_uop_pkg::div_u) ? '1 : a;
        end
        case (op)
            exe_uop_pkg::div_s: return ovf ? min_val : word_t'($signed(a) / $signed(b));
            exe_uop_pkg::div_u: return a / b;
            exe_uop_pkg::mod_s: return ovf ? '0 : word_t'($signed(a) % $signed(b));
            default:            return a % b;
        endcase
    endfunction

    task automatic end_run();
        int assert_errs;
        assert_errs = dut.u_props.fail_cnt;
        $display("errors: data %0d, protocol %0d, checks %0d, assertions %0d, timeouts %0d",
                 data_errs, proto_errs, check_errs, assert_errs, timeouts);
        if (data_errs + proto_errs + check_errs + assert_errs + timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // called at 2 ns after an edge, returns at the same phase after acceptance
    task automatic issue(input exe_uop_pkg::op_class_e cls, input exe_uop_pkg::alu_op_e aop,
                         input exe_uop_pkg::div_op_e dop, input word_t s0, input word_t s1,
                         input word_t imm, input logic use_imm);
        int  waited;
        rd_t rd;
        waited = 0;
        rd = rd_t'(lcg_next());
        in_valid = 1'b1;
        in_class = cls;
        in_alu_op = aop;
        in_div_op = dop;
        in_rd = rd;
        in_src0 = s0;
        in_src1 = s1;
        in_imm = imm;
        in_use_imm = use_imm;
        while (stall && waited < 100) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (stall) begin
            $display("timeout: stall stayed high for %0d cycles with an operation held", waited);
            timeouts++;
            in_valid = 1'b0;
        end else begin
            if (cls == exe_uop_pkg::cls_alu) begin
                exp_data.push_back(alu_model(aop, s0, use_imm ? imm : s1));
                exp_cyc.push_back(cyc + 1);
            end else begin
                exp_data.push_back(div_model(dop, s0, s1));
                exp_cyc.push_back(cyc + exe_cfg_pkg::div_steps + 2);
            end
            exp_rd.push_back(rd);
            accepted++;
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
    endtask

    always @(negedge clk) begin : wb_monitor
        if (arst_n && wb_valid) begin
            wb_seen++;
            if (rd_idx >= exp_data.size()) begin
                $display("writeback in cycle %0d with no operation outstanding", cyc);
                proto_errs++;
            end else begin
                if (wb_data !== exp_data[rd_idx]) begin
                    $display("** Error: wb_data expected 0x%h actual 0x%h",
                             exp_data[rd_idx], wb_data);
                    data_errs++;
                end
                if (wb_rd !== exp_rd[rd_idx]) begin
                    $display("** Error: wb_rd expected 0x%h actual 0x%h", exp_rd[rd_idx], wb_rd);
                    data_errs++;
                end
                if (cyc != exp_cyc[rd_idx]) begin
                    $display("writeback came in cycle %0d instead of cycle %0d",
                             cyc, exp_cyc[rd_idx]);
                    proto_errs++;
                end
                rd_idx++;
            end
        end
    end

    initial begin : main
        word_t                min_word;
        word_t                a;
        word_t                b;
        exe_uop_pkg::div_op_e dop;
        int                   waited;
        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_class = exe_uop_pkg::cls_alu;
        in_alu_op = exe_uop_pkg::alu_add;
        in_div_op = exe_uop_pkg::div_s;
        in_rd = '0;
        in_src0 = '0;
        in_src1 = '0;
        in_imm = '0;
        in_use_imm = 1'b0;
        min_word = '0;
        min_word[exe_cfg_pkg::data_w-1] = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(posedge clk);
        #2;
        if (wb_valid !== 1'b0) begin
            $display("** Error: wb_valid expected 0x0 actual 0x%h", wb_valid);
            check_errs++;
        end
        if (stall !== 1'b0) begin
            $display("** Error: stall expected 0x0 actual 0x%h", stall);
            check_errs++;
        end
        // back-to-back alu ops, every opcode in turn
        for (int n = 0; n < 220; n++) begin
            issue(exe_uop_pkg::cls_alu, exe_uop_pkg::alu_op_e'(4'(n % 11)), exe_uop_pkg::div_s,
                  rand32(), rand32(), rand32(), 1'(lcg_next()));
        end
        for (int n = 0; n < 60; n++) begin
            a = rand32();
            b = rand32() >> (lcg_next() % 16'd32);
            if ((lcg_next() % 16'd2) == 16'd1) begin
                b = -b;
            end
            // the immediate must never reach the divider
            issue(exe_uop_pkg::cls_div, exe_uop_pkg::alu_add,
                  exe_uop_pkg::div_op_e'(2'(lcg_next())), a, b, rand32(), 1'(lcg_next()));
            // presented while stall is high, so it is held
            if ((lcg_next() % 16'd2) == 16'd0) begin
                issue(exe_uop_pkg::cls_alu, exe_uop_pkg::alu_op_e'(4'(lcg_next() % 16'd11)),
                      exe_uop_pkg::div_s, rand32(), rand32(), rand32(), 1'(lcg_next()));
            end
        end
        for (int k = 0; k < 4; k++) begin
            dop = exe_uop_pkg::div_op_e'(2'(k));
            issue(exe_uop_pkg::cls_div, exe_uop_pkg::alu_add, dop, rand32(), '0, '0, 1'b0);
            issue(exe_uop_pkg::cls_div, exe_uop_pkg::alu_add, dop, min_word, '1, '0, 1'b0);
            issue(exe_uop_pkg::cls_div, exe_uop_pkg::alu_add, dop, rand32(), 'd1, '0, 1'b0);
            issue(exe_uop_pkg::cls_div, exe_uop_pkg::alu_add, dop, rand32(), '1, '0, 1'b0);
            issue(exe_uop_pkg::cls_div, exe_uop_pkg::alu_add, dop, '0, rand32(), '0, 1'b0);
        end
        waited = 0;
        while (rd_idx < exp_data.size() && waited < 200) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (rd_idx < exp_data.size()) begin
            $display("timeout: %0d writebacks never arrived", exp_data.size() - rd_idx);
            timeouts++;
        end else begin
            repeat (8) @(posedge clk);
            if (wb_seen != accepted) begin
                $display("saw %0d writebacks for %0d accepted operations", wb_seen, accepted);
                check_errs++;
            end
        end
        end_run();
    end

endmodule

//--- exe_unit.f
exe_cfg_pkg.sv
exe_uop_pkg.sv
exe_alu.sv
div_ctrl.sv
div_step_counter.sv
div_datapath.sv
exe_writeback.sv
exe_top.sv
exe_properties.sv
tb_exe.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert --top-module tb_exe -f exe_unit.f -o sim_exe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_exe > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
